// ==== design/axil_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_arbiter
  import fetch_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  // master 0, read only.
  input  logic                m0_arvalid_i,
  input  logic [ADDR_W-1:0]   m0_araddr_i,
  output logic                m0_arready_o,
  output logic                m0_rvalid_o,
  output logic [DATA_W-1:0]   m0_rdata_o,
  input  logic                m0_rready_i,
  // master 1.
  input  logic                m1_awvalid_i,
  input  logic [ADDR_W-1:0]   m1_awaddr_i,
  output logic                m1_awready_o,
  input  logic                m1_wvalid_i,
  input  logic [DATA_W-1:0]   m1_wdata_i,
  input  logic [DATA_W/8-1:0] m1_wstrb_i,
  output logic                m1_wready_o,
  output logic                m1_bvalid_o,
  output axi_resp_e           m1_bresp_o,
  input  logic                m1_bready_i,
  input  logic                m1_arvalid_i,
  input  logic [ADDR_W-1:0]   m1_araddr_i,
  output logic                m1_arready_o,
  output logic                m1_rvalid_o,
  output logic [DATA_W-1:0]   m1_rdata_o,
  output axi_resp_e           m1_rresp_o,
  input  logic                m1_rready_i,
  // slave.
  output logic                s_awvalid_o,
  output logic [ADDR_W-1:0]   s_awaddr_o,
  input  logic                s_awready_i,
  output logic                s_wvalid_o,
  output logic [DATA_W-1:0]   s_wdata_o,
  output logic [DATA_W/8-1:0] s_wstrb_o,
  input  logic                s_wready_i,
  input  logic                s_bvalid_i,
  input  axi_resp_e           s_bresp_i,
  output logic                s_bready_o,
  output logic                s_arvalid_o,
  output logic [ADDR_W-1:0]   s_araddr_o,
  input  logic                s_arready_i,
  input  logic                s_rvalid_i,
  input  logic [DATA_W-1:0]   s_rdata_i,
  input  axi_resp_e           s_rresp_i,
  output logic                s_rready_o
);

  logic busy_q;
  logic owner_q; // 1 means master 1.
  logic last_q;
  logic req0;
  logic req1;
  logic pick;
  logic sel0;
  logic sel1;
  logic done;

  assign req0 = m0_arvalid_i;
  assign req1 = m1_arvalid_i || m1_awvalid_i;
  assign pick = (req0 && req1) ? !last_q : req1;

  assign sel0 = busy_q && !owner_q;
  assign sel1 = busy_q && owner_q;

  // last response handshake ends the transaction.
  assign done = (sel0 && s_rvalid_i && m0_rready_i)
             || (sel1 && s_rvalid_i && m1_rready_i)
             || (sel1 && s_bvalid_i && m1_bready_i);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
      last_q  <= 1'b1;
    end
    else if (!busy_q)
    begin
      if (req0 || req1)
      begin
        busy_q  <= 1'b1;
        owner_q <= pick;
        last_q  <= pick;
      end
    end
    else if (done)
      busy_q <= 1'b0;
  end

  assign s_arvalid_o = (sel0 && m0_arvalid_i) || (sel1 && m1_arvalid_i);
  assign s_araddr_o  = owner_q ? m1_araddr_i : m0_araddr_i;
  assign s_rready_o  = (sel0 && m0_rready_i) || (sel1 && m1_rready_i);
  assign s_awvalid_o = sel1 && m1_awvalid_i;
  assign s_awaddr_o  = m1_awaddr_i;
  assign s_wvalid_o  = sel1 && m1_wvalid_i;
  assign s_wdata_o   = m1_wdata_i;
  assign s_wstrb_o   = m1_wstrb_i;
  assign s_bready_o  = sel1 && m1_bready_i;

  assign m0_arready_o = sel0 && s_arready_i;
  assign m0_rvalid_o  = sel0 && s_rvalid_i;
  assign m0_rdata_o   = s_rdata_i;

  assign m1_awready_o = sel1 && s_awready_i;
  assign m1_wready_o  = sel1 && s_wready_i;
  assign m1_bvalid_o  = sel1 && s_bvalid_i;
  assign m1_bresp_o   = s_bresp_i;
  assign m1_arready_o = sel1 && s_arready_i;
  assign m1_rvalid_o  = sel1 && s_rvalid_i;
  assign m1_rdata_o   = s_rdata_i;
  assign m1_rresp_o   = s_rresp_i;

endmodule

`default_nettype wire

// ==== design/axil_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_sram
  import fetch_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                s_awvalid_i,
  input  logic [ADDR_W-1:0]   s_awaddr_i,
  output logic                s_awready_o,
  input  logic                s_wvalid_i,
  input  logic [DATA_W-1:0]   s_wdata_i,
  input  logic [DATA_W/8-1:0] s_wstrb_i,
  output logic                s_wready_o,
  output logic                s_bvalid_o,
  output axi_resp_e           s_bresp_o,
  input  logic                s_bready_i,
  input  logic                s_arvalid_i,
  input  logic [ADDR_W-1:0]   s_araddr_i,
  output logic                s_arready_o,
  output logic                s_rvalid_o,
  output logic [DATA_W-1:0]   s_rdata_o,
  output axi_resp_e           s_rresp_o,
  input  logic                s_rready_i
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic bvalid_q;
  logic rvalid_q;
  logic [DATA_W-1:0] rdata_q;
  logic free;
  logic wr_go;
  logic rd_go;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;

  assign wr_idx = s_awaddr_i[IDX_W+1:2];
  assign rd_idx = s_araddr_i[IDX_W+1:2];

  // one transaction at a time, writes first.
  assign free  = !bvalid_q && !rvalid_q;
  assign wr_go = free && s_awvalid_i && s_wvalid_i;
  assign rd_go = free && s_arvalid_i && !wr_go;

  assign s_awready_o = wr_go;
  assign s_wready_o  = wr_go;
  assign s_arready_o = rd_go;
  assign s_bvalid_o  = bvalid_q;
  assign s_bresp_o   = OKAY;
  assign s_rvalid_o  = rvalid_q;
  assign s_rdata_o   = rdata_q;
  assign s_rresp_o   = OKAY;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      if (wr_go)
        bvalid_q <= 1'b1;
      else if (s_bready_i)
        bvalid_q <= 1'b0;
      if (rd_go)
        rvalid_q <= 1'b1;
      else if (s_rready_i)
        rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_go)
    begin
      for (int b = 0; b < DATA_W/8; b++)
      begin
        if (s_wstrb_i[b])
          mem[wr_idx][8*b +: 8] <= s_wdata_i[8*b +: 8];
      end
    end
    if (rd_go)
      rdata_q <= mem[rd_idx];
  end

endmodule

`default_nettype wire

// ==== design/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // flushes the whole icache when fetched.
  localparam logic [DATA_W-1:0] FENCE_I_WORD = 32'h0000100f;

  typedef enum logic
  {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_op_e;

  typedef enum logic [1:0]
  {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  typedef enum logic [2:0]
  {
    IFU_IDLE,
    IFU_LOOKUP, // tag compare.
    IFU_AR,
    IFU_R,
    IFU_HOLD    // result out, waits for inst_ready_i.
  } ifu_state_e;

endpackage

`default_nettype wire

// ==== design/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top
  import fetch_pkg::*;
#(
  parameter int ICACHE_LINES = 4,
  parameter int MEM_WORDS    = 256
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              fetch_valid_i,
  input  logic [ADDR_W-1:0] fetch_pc_i,
  output logic              fetch_ready_o,
  output logic              inst_valid_o,
  output logic [DATA_W-1:0] inst_o,
  output logic [ADDR_W-1:0] inst_pc_o,
  input  logic              inst_ready_i,
  input  logic              req_valid_i,
  input  mem_op_e           req_op_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic [DATA_W-1:0] req_wdata_i,
  output logic              req_ready_o,
  output logic              resp_valid_o,
  output logic [DATA_W-1:0] resp_rdata_o,
  input  logic              resp_ready_i
);

  // fetch unit side of the arbiter.
  logic m0_arvalid, m0_arready, m0_rvalid, m0_rready;
  logic [ADDR_W-1:0] m0_araddr;
  logic [DATA_W-1:0] m0_rdata;

  // load/store side.
  logic m1_awvalid, m1_awready, m1_wvalid, m1_wready, m1_bvalid, m1_bready;
  logic m1_arvalid, m1_arready, m1_rvalid, m1_rready;
  logic [ADDR_W-1:0] m1_awaddr, m1_araddr;
  logic [DATA_W-1:0] m1_wdata, m1_rdata;
  logic [DATA_W/8-1:0] m1_wstrb;
  axi_resp_e m1_bresp, m1_rresp;

  // memory side.
  logic s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
  logic s_arvalid, s_arready, s_rvalid, s_rready;
  logic [ADDR_W-1:0] s_awaddr, s_araddr;
  logic [DATA_W-1:0] s_wdata, s_rdata;
  logic [DATA_W/8-1:0] s_wstrb;
  axi_resp_e s_bresp, s_rresp;

  ifu #(.ICACHE_LINES(ICACHE_LINES)) u_ifu (
    .clk(clk), .rst(rst),
    .fetch_valid_i(fetch_valid_i), .fetch_pc_i(fetch_pc_i), .fetch_ready_o(fetch_ready_o),
    .inst_valid_o(inst_valid_o), .inst_o(inst_o), .inst_pc_o(inst_pc_o),
    .inst_ready_i(inst_ready_i),
    .m_arvalid_o(m0_arvalid), .m_araddr_o(m0_araddr), .m_arready_i(m0_arready),
    .m_rvalid_i(m0_rvalid), .m_rdata_i(m0_rdata), .m_rready_o(m0_rready)
  );

  lsu u_lsu (
    .clk(clk), .rst(rst),
    .req_valid_i(req_valid_i), .req_op_i(req_op_i), .req_addr_i(req_addr_i),
    .req_wdata_i(req_wdata_i), .req_ready_o(req_ready_o),
    .resp_valid_o(resp_valid_o), .resp_rdata_o(resp_rdata_o), .resp_ready_i(resp_ready_i),
    .m_awvalid_o(m1_awvalid), .m_awaddr_o(m1_awaddr), .m_awready_i(m1_awready),
    .m_wvalid_o(m1_wvalid), .m_wdata_o(m1_wdata), .m_wstrb_o(m1_wstrb),
    .m_wready_i(m1_wready),
    .m_bvalid_i(m1_bvalid), .m_bresp_i(m1_bresp), .m_bready_o(m1_bready),
    .m_arvalid_o(m1_arvalid), .m_araddr_o(m1_araddr), .m_arready_i(m1_arready),
    .m_rvalid_i(m1_rvalid), .m_rdata_i(m1_rdata), .m_rresp_i(m1_rresp),
    .m_rready_o(m1_rready)
  );

  axil_arbiter u_arb (
    .clk(clk), .rst(rst),
    .m0_arvalid_i(m0_arvalid), .m0_araddr_i(m0_araddr), .m0_arready_o(m0_arready),
    .m0_rvalid_o(m0_rvalid), .m0_rdata_o(m0_rdata), .m0_rready_i(m0_rready),
    .m1_awvalid_i(m1_awvalid), .m1_awaddr_i(m1_awaddr), .m1_awready_o(m1_awready),
    .m1_wvalid_i(m1_wvalid), .m1_wdata_i(m1_wdata), .m1_wstrb_i(m1_wstrb),
    .m1_wready_o(m1_wready),
    .m1_bvalid_o(m1_bvalid), .m1_bresp_o(m1_bresp), .m1_bready_i(m1_bready),
    .m1_arvalid_i(m1_arvalid), .m1_araddr_i(m1_araddr), .m1_arready_o(m1_arready),
    .m1_rvalid_o(m1_rvalid), .m1_rdata_o(m1_rdata), .m1_rresp_o(m1_rresp),
    .m1_rready_i(m1_rready),
    .s_awvalid_o(s_awvalid), .s_awaddr_o(s_awaddr), .s_awready_i(s_awready),
    .s_wvalid_o(s_wvalid), .s_wdata_o(s_wdata), .s_wstrb_o(s_wstrb), .s_wready_i(s_wready),
    .s_bvalid_i(s_bvalid), .s_bresp_i(s_bresp), .s_bready_o(s_bready),
    .s_arvalid_o(s_arvalid), .s_araddr_o(s_araddr), .s_arready_i(s_arready),
    .s_rvalid_i(s_rvalid), .s_rdata_i(s_rdata), .s_rresp_i(s_rresp), .s_rready_o(s_rready)
  );

  axil_sram #(.MEM_WORDS(MEM_WORDS)) u_sram (
    .clk(clk), .rst(rst),
    .s_awvalid_i(s_awvalid), .s_awaddr_i(s_awaddr), .s_awready_o(s_awready),
    .s_wvalid_i(s_wvalid), .s_wdata_i(s_wdata), .s_wstrb_i(s_wstrb), .s_wready_o(s_wready),
    .s_bvalid_o(s_bvalid), .s_bresp_o(s_bresp), .s_bready_i(s_bready),
    .s_arvalid_i(s_arvalid), .s_araddr_i(s_araddr), .s_arready_o(s_arready),
    .s_rvalid_o(s_rvalid), .s_rdata_o(s_rdata), .s_rresp_o(s_rresp), .s_rready_i(s_rready)
  );

endmodule

`default_nettype wire

// ==== design/ifu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifu
  import fetch_pkg::*;
#(
  parameter int ICACHE_LINES = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              fetch_valid_i,
  input  logic [ADDR_W-1:0] fetch_pc_i,
  output logic              fetch_ready_o,
  output logic              inst_valid_o,
  output logic [DATA_W-1:0] inst_o,
  output logic [ADDR_W-1:0] inst_pc_o,
  input  logic              inst_ready_i,
  output logic              m_arvalid_o,
  output logic [ADDR_W-1:0] m_araddr_o,
  input  logic              m_arready_i,
  input  logic              m_rvalid_i,
  input  logic [DATA_W-1:0] m_rdata_i,
  output logic              m_rready_o
);

  localparam int IDX_W = $clog2(ICACHE_LINES);
  localparam int TAG_W = ADDR_W - IDX_W - 2;

  ifu_state_e state_q;
  logic [ADDR_W-1:0] pc_q;
  logic [DATA_W-1:0] inst_q;
  logic [DATA_W-1:0] line_data [ICACHE_LINES];
  logic [TAG_W-1:0] line_tag [ICACHE_LINES];
  logic [ICACHE_LINES-1:0] line_valid;
  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;
  logic hit;

  assign idx = pc_q[IDX_W+1:2];
  assign tag = pc_q[ADDR_W-1:IDX_W+2];
  assign hit = line_valid[idx] && (line_tag[idx] == tag);

  assign fetch_ready_o = (state_q == IFU_IDLE);
  assign inst_valid_o  = (state_q == IFU_HOLD);
  assign inst_o        = inst_q;
  assign inst_pc_o     = pc_q;
  assign m_arvalid_o   = (state_q == IFU_AR);
  assign m_araddr_o    = {pc_q[ADDR_W-1:2], 2'b00}; // word aligned.
  assign m_rready_o    = (state_q == IFU_R);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q    <= IFU_IDLE;
      line_valid <= '0;
    end
    else
    begin
      case (state_q)
        IFU_IDLE:
          if (fetch_valid_i)
            state_q <= IFU_LOOKUP;
        IFU_LOOKUP:
          if (hit)
            state_q <= IFU_HOLD;
          else
            state_q <= IFU_AR;
        IFU_AR:
          if (m_arready_i)
            state_q <= IFU_R;
        IFU_R:
          if (m_rvalid_i)
          begin
            state_q         <= IFU_HOLD;
            line_valid[idx] <= 1'b1;
            // flush wins over the fill.
            if (m_rdata_i == FENCE_I_WORD)
              line_valid <= '0;
          end
        IFU_HOLD:
          if (inst_ready_i)
            state_q <= IFU_IDLE;
        default:
          state_q <= IFU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (fetch_valid_i && fetch_ready_o)
      pc_q <= fetch_pc_i;
    if ((state_q == IFU_LOOKUP) && hit)
      inst_q <= line_data[idx];
    if (m_rvalid_i && m_rready_o)
    begin
      inst_q         <= m_rdata_i;
      line_data[idx] <= m_rdata_i;
      line_tag[idx]  <= tag;
    end
  end

endmodule

`default_nettype wire

// ==== design/lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu
  import fetch_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid_i,
  input  mem_op_e               req_op_i,
  input  logic [ADDR_W-1:0]     req_addr_i,
  input  logic [DATA_W-1:0]     req_wdata_i,
  output logic                  req_ready_o,
  output logic                  resp_valid_o,
  output logic [DATA_W-1:0]     resp_rdata_o,
  input  logic                  resp_ready_i,
  output logic                  m_awvalid_o,
  output logic [ADDR_W-1:0]     m_awaddr_o,
  input  logic                  m_awready_i,
  output logic                  m_wvalid_o,
  output logic [DATA_W-1:0]     m_wdata_o,
  output logic [DATA_W/8-1:0]   m_wstrb_o,
  input  logic                  m_wready_i,
  input  logic                  m_bvalid_i,
  input  axi_resp_e             m_bresp_i,
  output logic                  m_bready_o,
  output logic                  m_arvalid_o,
  output logic [ADDR_W-1:0]     m_araddr_o,
  input  logic                  m_arready_i,
  input  logic                  m_rvalid_i,
  input  logic [DATA_W-1:0]     m_rdata_i,
  input  axi_resp_e             m_rresp_i,
  output logic                  m_rready_o
);

  typedef enum logic [2:0]
  {
    LSU_IDLE,
    LSU_WRITE, // aw and w out.
    LSU_B,
    LSU_AR,
    LSU_R,
    LSU_HOLD
  } lsu_state_e;

  lsu_state_e state_q;
  logic aw_done_q;
  logic w_done_q;
  logic aw_fire;
  logic w_fire;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [DATA_W-1:0] rdata_q;

  assign req_ready_o  = (state_q == LSU_IDLE);
  assign resp_valid_o = (state_q == LSU_HOLD);
  assign resp_rdata_o = rdata_q;

  assign m_awvalid_o = (state_q == LSU_WRITE) && !aw_done_q;
  assign m_wvalid_o  = (state_q == LSU_WRITE) && !w_done_q;
  assign m_awaddr_o  = addr_q;
  assign m_wdata_o   = wdata_q;
  assign m_wstrb_o   = '1;
  assign m_bready_o  = (state_q == LSU_B);
  assign m_arvalid_o = (state_q == LSU_AR);
  assign m_araddr_o  = addr_q;
  assign m_rready_o  = (state_q == LSU_R);

  assign aw_fire = m_awvalid_o && m_awready_i;
  assign w_fire  = m_wvalid_o && m_wready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= LSU_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        LSU_IDLE:
          if (req_valid_i)
            state_q <= (req_op_i == MEM_STORE) ? LSU_WRITE : LSU_AR;
        LSU_WRITE:
          if ((aw_done_q || aw_fire) && (w_done_q || w_fire))
          begin
            state_q   <= LSU_B;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end
          else
          begin
            aw_done_q <= aw_done_q || aw_fire;
            w_done_q  <= w_done_q || w_fire;
          end
        LSU_B:
          if (m_bvalid_i)
            state_q <= LSU_HOLD;
        LSU_AR:
          if (m_arready_i)
            state_q <= LSU_R;
        LSU_R:
          if (m_rvalid_i)
            state_q <= LSU_HOLD;
        LSU_HOLD:
          if (resp_ready_i)
            state_q <= LSU_IDLE;
        default:
          state_q <= LSU_IDLE;
      endcase
    end
  end

  // all ones in rdata flags a bad response.
  always_ff @(posedge clk)
  begin
    if (req_valid_i && req_ready_o)
    begin
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
    end
    if (m_bvalid_i && m_bready_o)
      rdata_q <= (m_bresp_i == OKAY) ? '0 : '1;
    if (m_rvalid_i && m_rready_o)
      rdata_q <= (m_rresp_i == OKAY) ? m_rdata_i : '1;
  end

endmodule

`default_nettype wire

// ==== dv/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_tb
  import fetch_pkg::*;
();

  localparam int ICACHE_LINES = 4;
  localparam int MEM_WORDS    = 256;
  localparam int LINE_W       = $clog2(ICACHE_LINES);
  localparam int WORD_W       = $clog2(MEM_WORDS);
  localparam int N_RAND       = 24;
  localparam int N_MIX        = 40;
  localparam int N_OPS        = MEM_WORDS + 3 * N_RAND + 6 + 2 * N_MIX + 8;
  localparam int CYCLES_PER_OP = 40;
  localparam longint TIMEOUT_NS = longint'(N_OPS) * CYCLES_PER_OP * 100;

  logic clk;
  logic rst;
  logic fetch_valid_i;
  logic [ADDR_W-1:0] fetch_pc_i;
  logic fetch_ready_o;
  logic inst_valid_o;
  logic [DATA_W-1:0] inst_o;
  logic [ADDR_W-1:0] inst_pc_o;
  logic inst_ready_i;
  logic req_valid_i;
  mem_op_e req_op_i;
  logic [ADDR_W-1:0] req_addr_i;
  logic [DATA_W-1:0] req_wdata_i;
  logic req_ready_o;
  logic resp_valid_o;
  logic [DATA_W-1:0] resp_rdata_o;
  logic resp_ready_i;

  // reference model.
  logic [DATA_W-1:0] mem_model [MEM_WORDS];
  logic [DATA_W-1:0] c_data [ICACHE_LINES];
  logic [ADDR_W-LINE_W-3:0] c_tag [ICACHE_LINES];
  logic [ICACHE_LINES-1:0] c_valid;
  int errors;
  int checks;

  fetch_top #(
    .ICACHE_LINES(ICACHE_LINES),
    .MEM_WORDS(MEM_WORDS)
  ) DUT (
    .clk(clk), .rst(rst),
    .fetch_valid_i(fetch_valid_i), .fetch_pc_i(fetch_pc_i), .fetch_ready_o(fetch_ready_o),
    .inst_valid_o(inst_valid_o), .inst_o(inst_o), .inst_pc_o(inst_pc_o),
    .inst_ready_i(inst_ready_i),
    .req_valid_i(req_valid_i), .req_op_i(req_op_i), .req_addr_i(req_addr_i),
    .req_wdata_i(req_wdata_i), .req_ready_o(req_ready_o),
    .resp_valid_o(resp_valid_o), .resp_rdata_o(resp_rdata_o), .resp_ready_i(resp_ready_i)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [DATA_W-1:0] rand_word();
    logic [DATA_W-1:0] w;
    w = $urandom;
    if (w == FENCE_I_WORD)
      w = w ^ 32'h1; // keep random code free of fences.
    return w;
  endfunction

  function automatic logic random_ready();
    return ($urandom % 4) != 0;
  endfunction

  function automatic logic [ADDR_W-1:0] addr_of(logic [WORD_W-1:0] mi);
    return {{(ADDR_W-WORD_W-2){1'b0}}, mi, 2'b00};
  endfunction

  // direct-mapped, one word per line, fence.i flushes all lines.
  function automatic logic [DATA_W-1:0] model_fetch(logic [ADDR_W-1:0] pc);
    logic [LINE_W-1:0] line;
    logic [ADDR_W-LINE_W-3:0] tag;
    logic [DATA_W-1:0] word;
    line = pc[LINE_W+1:2];
    tag  = pc[ADDR_W-1:LINE_W+2];
    if (c_valid[line] && (c_tag[line] == tag))
      word = c_data[line];
    else
    begin
      word          = mem_model[pc[WORD_W+1:2]];
      c_valid[line] = 1'b1;
      c_tag[line]   = tag;
      c_data[line]  = word;
    end
    if (word == FENCE_I_WORD)
      c_valid = '0;
    return word;
  endfunction

  task automatic check_inst(logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp,
                            logic [ADDR_W-1:0] got_pc, logic [ADDR_W-1:0] exp_pc);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t ns: inst_o got %h expected %h", $time, got, exp);
    end
    if (got_pc !== exp_pc)
    begin
      errors++;
      $display("CHECK FAILED at %0t ns: inst_pc_o got %h expected %h", $time, got_pc, exp_pc);
    end
  endtask

  task automatic check_resp(logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t ns: resp_rdata_o got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic fetch(logic [ADDR_W-1:0] pc, output logic [DATA_W-1:0] inst,
                       output logic [ADDR_W-1:0] ipc);
    @(negedge clk);
    fetch_valid_i = 1'b1;
    fetch_pc_i    = pc;
    while (!fetch_ready_o)
      @(negedge clk);
    @(negedge clk);
    fetch_valid_i = 1'b0;
    inst_ready_i  = random_ready();
    while (!(inst_valid_o && inst_ready_i))
    begin
      @(negedge clk);
      inst_ready_i = random_ready();
    end
    inst = inst_o;
    ipc  = inst_pc_o;
    @(negedge clk);
    inst_ready_i = 1'b0;
  endtask

  task automatic data_op(mem_op_e op, logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] wdata,
                         output logic [DATA_W-1:0] rdata);
    @(negedge clk);
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    while (!req_ready_o)
      @(negedge clk);
    @(negedge clk);
    req_valid_i  = 1'b0;
    resp_ready_i = random_ready();
    while (!(resp_valid_o && resp_ready_i))
    begin
      @(negedge clk);
      resp_ready_i = random_ready();
    end
    rdata = resp_rdata_o;
    @(negedge clk);
    resp_ready_i = 1'b0;
  endtask

  task automatic fetch_check(logic [WORD_W-1:0] mi);
    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] got_pc;
    logic [DATA_W-1:0] got;
    logic [DATA_W-1:0] exp;
    pc = addr_of(mi);
    fetch(pc, got, got_pc);
    exp = model_fetch(pc);
    check_inst(got, exp, got_pc, pc);
  endtask

  task automatic data_check(mem_op_e op, logic [WORD_W-1:0] mi, logic [DATA_W-1:0] wdata);
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] exp;
    exp = (op == MEM_STORE) ? '0 : mem_model[mi]; // stores answer with zero.
    data_op(op, addr_of(mi), wdata, rd);
    if (op == MEM_STORE)
      mem_model[mi] = wdata;
    check_resp(rd, exp);
  endtask

  task automatic report_test(string name, int base);
    $display("test %-16s %s (%0d errors)", name, (errors == base) ? "ok" : "failed",
             errors - base);
  endtask

  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout after %0d ns, the DUT stopped answering", TIMEOUT_NS);
    $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    int base;
    logic [WORD_W-1:0] mi;
    logic [WORD_W-1:0] mi_old;
    logic [WORD_W-1:0] mi_fence;
    void'($urandom(32'h6a13));
    errors        = 0;
    checks        = 0;
    c_valid       = '0;
    rst           = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_pc_i    = '0;
    inst_ready_i  = 1'b0;
    req_valid_i   = 1'b0;
    req_op_i      = MEM_LOAD;
    req_addr_i    = '0;
    req_wdata_i   = '0;
    resp_ready_i  = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    base = errors;
    for (int i = 0; i < MEM_WORDS; i++)
      data_check(MEM_STORE, WORD_W'(i), rand_word());
    for (int i = 0; i < N_RAND; i++)
      data_check(MEM_LOAD, WORD_W'($urandom), '0);
    report_test("stores/loads", base);

    base = errors;
    for (int i = 0; i < N_RAND; i++)
    begin
      mi = {1'b0, (WORD_W-1)'($urandom)};
      fetch_check(mi); // miss.
      fetch_check(mi); // hit.
    end
    report_test("miss/hit", base);

    base   = errors;
    mi_old = WORD_W'(8'h11);
    fetch_check(mi_old);
    data_check(MEM_STORE, mi_old, rand_word());
    fetch_check(mi_old); // old word still cached.
    report_test("stale code", base);

    base     = errors;
    mi_fence = WORD_W'(8'ha0); // upper half, never cached yet. other line than mi_old.
    data_check(MEM_STORE, mi_fence, FENCE_I_WORD);
    fetch_check(mi_fence);
    fetch_check(mi_old);
    report_test("fence.i", base);

    base = errors;
    fork
      for (int i = 0; i < N_MIX; i++)
        fetch_check({1'b0, (WORD_W-1)'($urandom)});
      // data traffic stays in the upper half.
      for (int i = 0; i < N_MIX; i++)
        data_check(($urandom % 2) ? MEM_STORE : MEM_LOAD, {1'b1, (WORD_W-1)'($urandom)},
                   rand_word());
    join
    repeat (4) @(negedge clk);
    if (inst_valid_o || resp_valid_o || !fetch_ready_o || !req_ready_o)
    begin
      errors++;
      $display("extra or missing result after mixed traffic at %0t ns", $time);
    end
    report_test("contention", base);

    base = errors;
    for (int i = 0; i < 4; i++)
    begin
      fetch_check(WORD_W'(8'h05));
      fetch_check(WORD_W'(8'h05 + ICACHE_LINES)); // same line, other tag.
    end
    report_test("index conflict", base);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# builds the fetch testbench with verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f src.f \
  --top-module fetch_tb -Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== src.f ====
design/fetch_pkg.sv
design/ifu.sv
design/lsu.sv
design/axil_arbiter.sv
design/axil_sram.sv
design/fetch_top.sv
dv/fetch_tb.sv
